// ==== bus_ctrl_defs.svh ====
// Board-control register block constants
// Bus widths, register map, compatibility number and reset values

`ifndef BUS_CTRL_DEFS_SVH
`define BUS_CTRL_DEFS_SVH

// Host bus widths
`define BUS_ADDR_W 8
`define BUS_DATA_W 32

// ------------------------------
// Write (setting) addresses
// ------------------------------
`define SR_LEDS        8'd0
`define SR_SW_RST      8'd1
`define SR_CLOCK_CTRL  8'd2
`define SR_DEVICE_ID   8'd3
`define SR_REF_FREQ    8'd4
`define SR_SFPP_CTRL0  8'd8
`define SR_SFPP_CTRL1  8'd9

// ------------------------------
// Readback addresses
// ------------------------------
`define RB_COUNTER      8'd0
`define RB_CLK_STATUS   8'd3
`define RB_COMPAT_NUM   8'd6
`define RB_RFNOC_INFO   8'd7
`define RB_SFPP_STATUS0 8'd8
`define RB_SFPP_STATUS1 8'd9

// Compatibility number and protocol version
`define COMPAT_MAJOR   16'h0026
`define COMPAT_MINOR   16'h0000
`define RFNOC_PROTOVER 16'h0100

// Bit 6 enables the GPSDO by default
`define CLOCK_CTRL_RESET 8'h40
// 10 MHz reference
`define REF_FREQ_RESET   32'd10_000_000

`define PHY_STATUS_W 16
`define SYNC_STAGES  2

`endif

// ==== bus_host_pkg.sv ====
// Host-side types of the board-control block
// Opcode, decoded register targets and the decoded command word

`default_nettype none

`include "bus_ctrl_defs.svh"

package bus_host_pkg;

   typedef enum logic {
      OP_WRITE = 1'b0,
      OP_READ  = 1'b1
   } bus_op_e;

   // Setting register hit by a write
   typedef enum logic [2:0] {
      LEDS,
      SW_RST,
      CLOCK_CTRL,
      DEVICE_ID,
      REF_FREQ,
      SFP0_CTRL,
      SFP1_CTRL,
      NONE
   } wr_target_e;

   // Readback source of a read
   typedef enum logic [2:0] {
      COUNTER,
      CLK_STATUS,
      COMPAT,
      RFNOC_INFO,
      SFP0_STATUS,
      SFP1_STATUS,
      ZERO
   } rd_target_e;

   typedef struct packed {
      bus_op_e                op;
      wr_target_e             wr_target;
      rd_target_e             rd_target;
      logic [`BUS_DATA_W-1:0] data;
   } bus_cmd_t;

endpackage

`default_nettype wire

// ==== bus_board_pkg.sv ====
// Board-side types of the board-control block
// SFP pin group, SFP status word and the readback snapshot

`default_nettype none

`include "bus_ctrl_defs.svh"

package bus_board_pkg;

   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // Status word as seen by the host
   typedef struct packed {
      logic [`PHY_STATUS_W-1:0] phy_status;
      logic [9:0]               rsvd;
      sfp_pins_t                changed;
      sfp_pins_t                pins;
   } sfp_status_t;

   typedef struct packed {
      logic [`BUS_DATA_W-1:0] counter;
      logic [15:0]            device_id;
      logic [7:0]             clock_status;
      sfp_status_t [1:0]      sfp;
   } board_state_t;

endpackage

`default_nettype wire

// ==== bus_cmd_if.sv ====
// Internal command path of the board-control block
// Decoded commands go from decode to execute, read snapshots
// from execute to the readback stage

`timescale 1ns/1ps
`default_nettype none

interface bus_cmd_if;
   import bus_host_pkg::*;
   import bus_board_pkg::*;

   // Command group
   logic         cmd_valid;
   bus_cmd_t     cmd;
   logic         cmd_ready;

   // Readback group
   logic         rb_valid;
   rd_target_e   rb_target;
   board_state_t rb_state;
   logic         rb_ready;

   modport decode_mp (
      output cmd_valid, cmd,
      input  cmd_ready
   );

   modport execute_mp (
      input  cmd_valid, cmd, rb_ready,
      output cmd_ready, rb_valid, rb_target, rb_state
   );

   modport result_mp (
      input  rb_valid, rb_target, rb_state,
      output rb_ready
   );

endinterface

`default_nettype wire

// ==== bus_cmd_decode.sv ====
// Host request decoder
// Accepts valid/ready requests, maps address and opcode onto
// register targets and holds one decoded command for execute

`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_defs.svh"

module bus_cmd_decode (
   input  wire                   clk,
   input  wire                   i_arst_n,
   input  wire                   i_req_valid,
   input  wire                   i_req_write,
   input  wire [`BUS_ADDR_W-1:0] i_req_addr,
   input  wire [`BUS_DATA_W-1:0] i_req_data,
   output logic                  o_req_ready,
   bus_cmd_if.decode_mp          cmd_if
);
   import bus_host_pkg::*;

   bus_cmd_t req_cmd;
   logic     accept;

   // ------------------------------
   // Address decode
   // ------------------------------
   always_comb begin
      req_cmd.op        = i_req_write ? OP_WRITE : OP_READ;
      req_cmd.data      = i_req_data;
      req_cmd.wr_target = NONE;
      req_cmd.rd_target = ZERO;
      if (i_req_write) begin
         case (i_req_addr)
            `SR_LEDS:       req_cmd.wr_target = LEDS;
            `SR_SW_RST:     req_cmd.wr_target = SW_RST;
            `SR_CLOCK_CTRL: req_cmd.wr_target = CLOCK_CTRL;
            `SR_DEVICE_ID:  req_cmd.wr_target = DEVICE_ID;
            `SR_REF_FREQ:   req_cmd.wr_target = REF_FREQ;
            `SR_SFPP_CTRL0: req_cmd.wr_target = SFP0_CTRL;
            `SR_SFPP_CTRL1: req_cmd.wr_target = SFP1_CTRL;
            default:        req_cmd.wr_target = NONE;
         endcase
      end else begin
         case (i_req_addr)
            `RB_COUNTER:      req_cmd.rd_target = COUNTER;
            `RB_CLK_STATUS:   req_cmd.rd_target = CLK_STATUS;
            `RB_COMPAT_NUM:   req_cmd.rd_target = COMPAT;
            `RB_RFNOC_INFO:   req_cmd.rd_target = RFNOC_INFO;
            `RB_SFPP_STATUS0: req_cmd.rd_target = SFP0_STATUS;
            `RB_SFPP_STATUS1: req_cmd.rd_target = SFP1_STATUS;
            default:          req_cmd.rd_target = ZERO;
         endcase
      end
   end

   // ------------------------------
   // One-entry command holding stage
   // ------------------------------
   // Free when empty or when the held command leaves this cycle
   assign o_req_ready = !cmd_if.cmd_valid || cmd_if.cmd_ready;
   assign accept      = i_req_valid && o_req_ready;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cmd_if.cmd_valid <= 1'b0;
      end else if (accept) begin
         cmd_if.cmd_valid <= 1'b1;
      end else if (cmd_if.cmd_ready) begin
         cmd_if.cmd_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_if.cmd <= req_cmd;
      end
   end

   // A stalled command must not change under execute
   a_cmd_stable : assert property (
      @(posedge clk) disable iff (!i_arst_n)
      cmd_if.cmd_valid && !cmd_if.cmd_ready |=> cmd_if.cmd_valid && $stable(cmd_if.cmd)
   );

endmodule

`default_nettype wire

// ==== bus_reg_execute.sv ====
// Register execute stage
// Holds the setting registers and free-running counter, synchronizes
// the SFP pins and PHY status, latches sticky pin changes and hands
// read snapshots to the readback stage

`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_defs.svh"

module bus_reg_execute (
   input  wire                     clk,
   input  wire                     i_arst_n,
   bus_cmd_if.execute_mp           cmd_if,
   input  wire [7:0]               i_clock_status,
   input  wire bus_board_pkg::sfp_pins_t i_sfp0_pins,
   input  wire bus_board_pkg::sfp_pins_t i_sfp1_pins,
   input  wire [`PHY_STATUS_W-1:0] i_sfp0_phy_status,
   input  wire [`PHY_STATUS_W-1:0] i_sfp1_phy_status,
   output logic [1:0]              o_leds,
   output logic [3:0]              o_sw_rst,
   output logic [7:0]              o_clock_control,
   output logic [`BUS_DATA_W-1:0]  o_ref_freq,
   output logic                    o_ref_freq_changed,
   output logic [1:0]              o_sfp0_rs_drive,
   output logic [1:0]              o_sfp1_rs_drive
);
   import bus_host_pkg::*;
   import bus_board_pkg::*;

   localparam int NUM_SFP = 2;

   logic                   wr_en;
   logic                   rd_en;
   logic [15:0]            device_id;
   logic [`BUS_DATA_W-1:0] counter;
   board_state_t           snap;

   sfp_pins_t [NUM_SFP-1:0]                                   pins_in;
   logic [NUM_SFP-1:0][`PHY_STATUS_W-1:0]                     phy_in;
   sfp_pins_t [NUM_SFP-1:0][`SYNC_STAGES-1:0]                 pins_sync;
   logic [NUM_SFP-1:0][`SYNC_STAGES-1:0][`PHY_STATUS_W-1:0]   phy_sync;
   sfp_pins_t [NUM_SFP-1:0]                                   pins_q;
   sfp_pins_t [NUM_SFP-1:0]                                   sticky;
   logic [NUM_SFP-1:0]                                        sticky_clr;

   // Writes never stall, reads wait for room in the response queue
   assign cmd_if.cmd_ready = (cmd_if.cmd.op == OP_WRITE) || cmd_if.rb_ready;
   assign wr_en = cmd_if.cmd_valid && (cmd_if.cmd.op == OP_WRITE);
   assign rd_en = cmd_if.cmd_valid && (cmd_if.cmd.op == OP_READ) && cmd_if.rb_ready;

   // ------------------------------
   // Setting registers
   // ------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_leds             <= '0;
         o_sw_rst           <= '0;
         o_clock_control    <= `CLOCK_CTRL_RESET;
         device_id          <= '0;
         o_ref_freq         <= `REF_FREQ_RESET;
         o_ref_freq_changed <= 1'b0;
         o_sfp0_rs_drive    <= '0;
         o_sfp1_rs_drive    <= '0;
      end else begin
         o_ref_freq_changed <= wr_en && (cmd_if.cmd.wr_target == REF_FREQ);
         if (wr_en) begin
            case (cmd_if.cmd.wr_target)
               LEDS:       o_leds          <= cmd_if.cmd.data[1:0];
               SW_RST:     o_sw_rst        <= cmd_if.cmd.data[3:0];
               CLOCK_CTRL: o_clock_control <= cmd_if.cmd.data[7:0];
               DEVICE_ID:  device_id       <= cmd_if.cmd.data[15:0];
               REF_FREQ:   o_ref_freq      <= cmd_if.cmd.data;
               SFP0_CTRL:  o_sfp0_rs_drive <= cmd_if.cmd.data[1:0];
               SFP1_CTRL:  o_sfp1_rs_drive <= cmd_if.cmd.data[1:0];
               default:    ;
            endcase
         end
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // ------------------------------
   // SFP synchronizers and sticky change bits
   // ------------------------------
   assign pins_in = {i_sfp1_pins, i_sfp0_pins};
   assign phy_in  = {i_sfp1_phy_status, i_sfp0_phy_status};

   assign sticky_clr[0] = rd_en && (cmd_if.cmd.rd_target == SFP0_STATUS);
   assign sticky_clr[1] = rd_en && (cmd_if.cmd.rd_target == SFP1_STATUS);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pins_sync <= '0;
         phy_sync  <= '0;
         pins_q    <= '0;
         sticky    <= '0;
      end else begin
         for (int s = 0; s < NUM_SFP; s++) begin
            pins_sync[s] <= {pins_sync[s][`SYNC_STAGES-2:0], pins_in[s]};
            phy_sync[s]  <= {phy_sync[s][`SYNC_STAGES-2:0], phy_in[s]};
            pins_q[s]    <= pins_sync[s][`SYNC_STAGES-1];
            // A change landing on the clearing edge still survives
            sticky[s] <= (sticky[s] & {3{!sticky_clr[s]}})
                         | (pins_sync[s][`SYNC_STAGES-1] ^ pins_q[s]);
         end
      end
   end

   // ------------------------------
   // Readback snapshot
   // ------------------------------
   always_comb begin
      snap.counter      = counter;
      snap.device_id    = device_id;
      snap.clock_status = i_clock_status;
      for (int s = 0; s < NUM_SFP; s++) begin
         snap.sfp[s].phy_status = phy_sync[s][`SYNC_STAGES-1];
         snap.sfp[s].rsvd       = '0;
         snap.sfp[s].changed    = sticky[s];
         snap.sfp[s].pins       = pins_sync[s][`SYNC_STAGES-1];
      end
   end

   assign cmd_if.rb_valid  = cmd_if.cmd_valid && (cmd_if.cmd.op == OP_READ);
   assign cmd_if.rb_target = cmd_if.cmd.rd_target;
   assign cmd_if.rb_state  = snap;

   // Change pulse only after a reference-frequency write whose data landed
   a_ref_freq_pulse : assert property (
      @(posedge clk) disable iff (!i_arst_n)
      o_ref_freq_changed |->
         $past(cmd_if.cmd_valid && (cmd_if.cmd.wr_target == REF_FREQ))
         && (o_ref_freq == $past(cmd_if.cmd.data))
   );

endmodule

`default_nettype wire

// ==== bus_readback_result.sv ====
// Readback result stage
// Picks the read word from target and snapshot and queues up to
// two words for the host response port

`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_defs.svh"

module bus_readback_result (
   input  wire                   clk,
   input  wire                   i_arst_n,
   bus_cmd_if.result_mp          cmd_if,
   output logic                  o_rsp_valid,
   output logic [`BUS_DATA_W-1:0] o_rsp_data,
   input  wire                   i_rsp_ready
);
   import bus_host_pkg::*;

   logic [`BUS_DATA_W-1:0] rb_word;
   logic [`BUS_DATA_W-1:0] q_mem [2];
   logic                   wr_ptr;
   logic                   rd_ptr;
   logic [1:0]             count;
   logic                   push;
   logic                   pop;

   // ------------------------------
   // Readback mux
   // ------------------------------
   always_comb begin
      case (cmd_if.rb_target)
         COUNTER:     rb_word = cmd_if.rb_state.counter;
         CLK_STATUS:  rb_word = {24'b0, cmd_if.rb_state.clock_status};
         COMPAT:      rb_word = {`COMPAT_MAJOR, `COMPAT_MINOR};
         RFNOC_INFO:  rb_word = {cmd_if.rb_state.device_id, `RFNOC_PROTOVER};
         SFP0_STATUS: rb_word = cmd_if.rb_state.sfp[0];
         SFP1_STATUS: rb_word = cmd_if.rb_state.sfp[1];
         default:     rb_word = '0;
      endcase
   end

   // ------------------------------
   // Two-entry response queue
   // ------------------------------
   assign cmd_if.rb_ready = (count != 2'd2);
   assign push            = cmd_if.rb_valid && cmd_if.rb_ready;
   assign o_rsp_valid     = (count != 2'd0);
   assign pop             = o_rsp_valid && i_rsp_ready;
   assign o_rsp_data      = q_mem[rd_ptr];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr <= !wr_ptr;
         end
         if (pop) begin
            rd_ptr <= !rd_ptr;
         end
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         q_mem[wr_ptr] <= rb_word;
      end
   end

   // Occupancy stays within two entries and agrees with the pointers
   a_no_overflow : assert property (
      @(posedge clk) disable iff (!i_arst_n)
      (count <= 2'd2) && ((count == 2'd1) == (wr_ptr != rd_ptr))
   );

endmodule

`default_nettype wire

// ==== bus_ctrl_top.sv ====
// Board-control register block, top level
// Host request and response ports in plain form; decode, execute
// and readback stages joined by the internal command interface

`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_defs.svh"

module bus_ctrl_top (
   input  wire                     clk,
   input  wire                     i_arst_n,
   // Host request port
   input  wire                     i_req_valid,
   input  wire                     i_req_write,
   input  wire [`BUS_ADDR_W-1:0]   i_req_addr,
   input  wire [`BUS_DATA_W-1:0]   i_req_data,
   output wire                     o_req_ready,
   // Host response port
   output wire                     o_rsp_valid,
   output wire [`BUS_DATA_W-1:0]   o_rsp_data,
   input  wire                     i_rsp_ready,
   // Board status
   input  wire [7:0]               i_clock_status,
   input  wire                     i_sfp0_mod_abs,
   input  wire                     i_sfp0_tx_fault,
   input  wire                     i_sfp0_rx_los,
   input  wire                     i_sfp1_mod_abs,
   input  wire                     i_sfp1_tx_fault,
   input  wire                     i_sfp1_rx_los,
   input  wire [`PHY_STATUS_W-1:0] i_sfp0_phy_status,
   input  wire [`PHY_STATUS_W-1:0] i_sfp1_phy_status,
   // Board settings
   output wire [1:0]               o_leds,
   output wire [3:0]               o_sw_rst,
   output wire [7:0]               o_clock_control,
   output wire [`BUS_DATA_W-1:0]   o_ref_freq,
   output wire                     o_ref_freq_changed,
   // Open-drain enables for the SFP rate-select pins
   output wire [1:0]               o_sfp0_rs_drive,
   output wire [1:0]               o_sfp1_rs_drive
);

   bus_cmd_if cmd_if ();

   bus_cmd_decode bus_cmd_decode_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req_valid (i_req_valid),
      .i_req_write (i_req_write),
      .i_req_addr  (i_req_addr),
      .i_req_data  (i_req_data),
      .o_req_ready (o_req_ready),
      .cmd_if      (cmd_if)
   );

   bus_reg_execute bus_reg_execute_inst (
      .clk                (clk),
      .i_arst_n           (i_arst_n),
      .cmd_if             (cmd_if),
      .i_clock_status     (i_clock_status),
      .i_sfp0_pins        ({i_sfp0_mod_abs, i_sfp0_tx_fault, i_sfp0_rx_los}),
      .i_sfp1_pins        ({i_sfp1_mod_abs, i_sfp1_tx_fault, i_sfp1_rx_los}),
      .i_sfp0_phy_status  (i_sfp0_phy_status),
      .i_sfp1_phy_status  (i_sfp1_phy_status),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_ref_freq         (o_ref_freq),
      .o_ref_freq_changed (o_ref_freq_changed),
      .o_sfp0_rs_drive    (o_sfp0_rs_drive),
      .o_sfp1_rs_drive    (o_sfp1_rs_drive)
   );

   bus_readback_result bus_readback_result_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .cmd_if      (cmd_if),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp_data  (o_rsp_data),
      .i_rsp_ready (i_rsp_ready)
   );

endmodule

`default_nettype wire

// ==== tb_bus_ctrl.sv ====
// Testbench for the board-control register block
// Drives host requests and board pins, predicts every read from a
// register model and checks responses and setting outputs

`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_defs.svh"

module tb_bus_ctrl;
   import bus_board_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int BURST_LEN   = 40;
   localparam int NUM_REQ     = 1 + 2 * 10 + 12 + 8 + BURST_LEN;
   localparam int WDOG_CYCLES = NUM_REQ * 20 + 8 + 200;
   localparam logic [31:0] SEED = 32'hc1a7fa97;

   // Kinds of entry in the expected-response queue
   localparam int K_WORD      = 0;
   localparam int K_STATUS    = 1;
   localparam int K_CNT_FIRST = 2;
   localparam int K_CNT_NEXT  = 3;

   localparam logic [7:0] WR_ADDRS [8] = '{`SR_LEDS, `SR_SW_RST, `SR_CLOCK_CTRL,
      `SR_DEVICE_ID, `SR_REF_FREQ, 8'h05, `SR_SFPP_CTRL0, `SR_SFPP_CTRL1};
   localparam logic [7:0] UNMAPPED [4] = '{8'h01, 8'h04, 8'h0a, 8'hff};
   localparam logic [7:0] BURST_ADDRS [7] = '{`RB_CLK_STATUS, `RB_COMPAT_NUM,
      `RB_RFNOC_INFO, `RB_SFPP_STATUS0, `RB_SFPP_STATUS1, 8'h05, 8'h42};

   logic        clk = 1'b0;
   logic        i_arst_n;
   logic        i_req_valid;
   logic        i_req_write;
   logic [7:0]  i_req_addr;
   logic [31:0] i_req_data;
   logic        o_req_ready;
   logic        o_rsp_valid;
   logic [31:0] o_rsp_data;
   logic        i_rsp_ready;
   logic [7:0]  i_clock_status;
   sfp_pins_t   sfp_pins [2];
   logic [15:0] phy_status [2];
   logic [1:0]  o_leds;
   logic [3:0]  o_sw_rst;
   logic [7:0]  o_clock_control;
   logic [31:0] o_ref_freq;
   logic        o_ref_freq_changed;
   logic [1:0]  o_sfp0_rs_drive;
   logic [1:0]  o_sfp1_rs_drive;

   // Register model
   logic [1:0]  m_leds;
   logic [3:0]  m_sw_rst;
   logic [7:0]  m_clock_ctrl;
   logic [15:0] m_device_id;
   logic [31:0] m_ref_freq;
   logic [1:0]  m_rs_drive [2];
   sfp_pins_t   m_sticky [2];

   logic [31:0] exp_data [$];
   int          exp_kind [$];
   int          err_count;
   int          fail_count;
   int          pulse_cycles;
   logic        bp_en;
   logic [31:0] data_seed;
   logic [31:0] bp_seed;
   logic [31:0] last_count;

   bus_ctrl_top bus_ctrl_top_inst (
      .clk (clk), .i_arst_n (i_arst_n),
      .i_req_valid (i_req_valid), .i_req_write (i_req_write),
      .i_req_addr (i_req_addr), .i_req_data (i_req_data), .o_req_ready (o_req_ready),
      .o_rsp_valid (o_rsp_valid), .o_rsp_data (o_rsp_data), .i_rsp_ready (i_rsp_ready),
      .i_clock_status (i_clock_status),
      .i_sfp0_mod_abs (sfp_pins[0].mod_abs), .i_sfp0_tx_fault (sfp_pins[0].tx_fault),
      .i_sfp0_rx_los (sfp_pins[0].rx_los), .i_sfp1_mod_abs (sfp_pins[1].mod_abs),
      .i_sfp1_tx_fault (sfp_pins[1].tx_fault), .i_sfp1_rx_los (sfp_pins[1].rx_los),
      .i_sfp0_phy_status (phy_status[0]), .i_sfp1_phy_status (phy_status[1]),
      .o_leds (o_leds), .o_sw_rst (o_sw_rst), .o_clock_control (o_clock_control),
      .o_ref_freq (o_ref_freq), .o_ref_freq_changed (o_ref_freq_changed),
      .o_sfp0_rs_drive (o_sfp0_rs_drive), .o_sfp1_rs_drive (o_sfp1_rs_drive)
   );

   // ------------------------------
   // Helpers and reference model
   // ------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rand_word();
      data_seed = lcg_next(data_seed);
      return data_seed;
   endfunction

   // Expected read word; the counter is checked by its step instead
   function automatic logic [31:0] predict_read(input logic [7:0] addr);
      sfp_status_t st;
      int          s;
      s = (addr == `RB_SFPP_STATUS1) ? 1 : 0;
      st = '0;
      st.phy_status = phy_status[s];
      st.changed    = m_sticky[s];
      st.pins       = sfp_pins[s];
      case (addr)
         `RB_CLK_STATUS:                     return {24'h0, i_clock_status};
         `RB_COMPAT_NUM:                     return 32'h0026_0000;
         `RB_RFNOC_INFO:                     return {m_device_id, 16'h0100};
         `RB_SFPP_STATUS0, `RB_SFPP_STATUS1: return st;
         default:                            return 32'h0;
      endcase
   endfunction

   task automatic check_word(input string name, input logic [`BUS_DATA_W-1:0] got,
                             input logic [`BUS_DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_status(input string name, input sfp_status_t got,
                               input sfp_status_t exp);
      if (got !== exp) begin
         $display("Error: %s got 0x%h expected 0x%h (changed 0x%h/0x%h pins 0x%h/0x%h)",
                  name, got, exp, got.changed, exp.changed, got.pins, exp.pins);
         err_count++;
      end
   endtask

   task automatic check_setting(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_settings();
      @(negedge clk);
      check_setting("o_leds", {30'h0, o_leds}, {30'h0, m_leds});
      check_setting("o_sw_rst", {28'h0, o_sw_rst}, {28'h0, m_sw_rst});
      check_setting("o_clock_control", {24'h0, o_clock_control}, {24'h0, m_clock_ctrl});
      check_setting("o_ref_freq", o_ref_freq, m_ref_freq);
      check_setting("o_ref_freq_changed", {31'h0, o_ref_freq_changed}, 32'h0);
      check_setting("o_sfp0_rs_drive", {30'h0, o_sfp0_rs_drive}, {30'h0, m_rs_drive[0]});
      check_setting("o_sfp1_rs_drive", {30'h0, o_sfp1_rs_drive}, {30'h0, m_rs_drive[1]});
   endtask

   // ------------------------------
   // Request tasks
   // ------------------------------
   task automatic send_request(input logic wr, input logic [7:0] addr,
                               input logic [31:0] data);
      @(negedge clk);
      i_req_valid = 1'b1;
      i_req_write = wr;
      i_req_addr  = addr;
      i_req_data  = data;
      // Ready comes from registered state only, so it is settled here
      while (!o_req_ready) @(negedge clk);
      @(posedge clk);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      send_request(1'b1, addr, data);
      case (addr)
         `SR_LEDS:       m_leds        = data[1:0];
         `SR_SW_RST:     m_sw_rst      = data[3:0];
         `SR_CLOCK_CTRL: m_clock_ctrl  = data[7:0];
         `SR_DEVICE_ID:  m_device_id   = data[15:0];
         `SR_REF_FREQ:   m_ref_freq    = data;
         `SR_SFPP_CTRL0: m_rs_drive[0] = data[1:0];
         `SR_SFPP_CTRL1: m_rs_drive[1] = data[1:0];
         default:        ;
      endcase
   endtask

   task automatic read_reg(input logic [7:0] addr);
      send_request(1'b0, addr, 32'h0);
      exp_data.push_back(predict_read(addr));
      if (addr == `RB_SFPP_STATUS0 || addr == `RB_SFPP_STATUS1) begin
         exp_kind.push_back(K_STATUS);
         m_sticky[addr == `RB_SFPP_STATUS1] = '0;
      end else begin
         exp_kind.push_back(K_WORD);
      end
   endtask

   task automatic read_counter(input logic first);
      send_request(1'b0, `RB_COUNTER, 32'h0);
      exp_data.push_back(32'h0);
      exp_kind.push_back(first ? K_CNT_FIRST : K_CNT_NEXT);
   endtask

   task automatic idle_cycles(input int n);
      @(negedge clk);
      i_req_valid = 1'b0;
      repeat (n) @(posedge clk);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_data.size() != 0 && waited < 200) begin
         @(negedge clk);
         waited++;
      end
      if (exp_data.size() != 0) begin
         $display("Responses missing: %0d reads were never answered", exp_data.size());
         fail_count++;
      end
   endtask

   // ------------------------------
   // Clock, back-pressure, monitors
   // ------------------------------
   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(negedge clk) begin
      if (bp_en) begin
         bp_seed = lcg_next(bp_seed);
         i_rsp_ready = bp_seed[20];
      end else begin
         i_rsp_ready = 1'b1;
      end
      if (o_ref_freq_changed) begin
         pulse_cycles++;
      end
   end

   always @(posedge clk) begin : compare_responses
      int          kind;
      logic [31:0] word;
      if (i_arst_n && o_rsp_valid && i_rsp_ready) begin
         if (exp_data.size() == 0) begin
            $display("Unexpected response 0x%h with no read outstanding", o_rsp_data);
            fail_count++;
         end else begin
            kind = exp_kind.pop_front();
            word = exp_data.pop_front();
            if (kind == K_STATUS) begin
               check_status("o_rsp_data", o_rsp_data, word);
            end else if (kind == K_CNT_NEXT) begin
               check_word("o_rsp_data counter step", o_rsp_data, last_count + 32'd1);
            end else if (kind == K_WORD) begin
               check_word("o_rsp_data", o_rsp_data, word);
            end
            last_count = o_rsp_data;
         end
      end
   end

   initial begin
      #(WDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, the run did not complete", WDOG_CYCLES);
      $display("Errors: %0d, other failures: %0d", err_count, fail_count + 1);
      $display("TEST FAIL");
      $finish;
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin : stimulus
      logic [31:0] r;
      sfp_pins_t   new_pins;
      i_arst_n = 1'b0;
      i_req_valid = 1'b0;
      i_req_write = 1'b0;
      i_req_addr = '0;
      i_req_data = '0;
      i_rsp_ready = 1'b1;
      i_clock_status = '0;
      sfp_pins = '{default: '0};
      phy_status = '{default: '0};
      m_leds = '0;
      m_sw_rst = '0;
      m_clock_ctrl = 8'h40;
      m_device_id = '0;
      m_ref_freq = 32'd10_000_000;
      m_rs_drive = '{default: '0};
      m_sticky = '{default: '0};
      err_count = 0;
      fail_count = 0;
      pulse_cycles = 0;
      bp_en = 1'b0;
      last_count = '0;
      data_seed = SEED;
      bp_seed = SEED ^ 32'hffff_0000;
      repeat (8) @(negedge clk);
      i_arst_n = 1'b1;
      r = rand_word();
      i_clock_status = r[7:0];

      // Reset values
      check_settings();
      check_setting("o_req_ready", {31'h0, o_req_ready}, 32'h1);
      check_setting("o_rsp_valid", {31'h0, o_rsp_valid}, 32'h0);
      read_reg(`RB_COMPAT_NUM);
      idle_cycles(1);
      wait_drain();

      // Settings writes with one REF_FREQ pulse per round
      for (int round = 0; round < 2; round++) begin
         foreach (WR_ADDRS[i]) begin
            write_reg(WR_ADDRS[i], rand_word());
         end
         read_reg(`RB_RFNOC_INFO);
         read_reg(`RB_CLK_STATUS);
         idle_cycles(3);
         check_settings();
         wait_drain();
      end
      check_setting("o_ref_freq_changed cycles", pulse_cycles, 32'd2);

      // Back-to-back counter reads and unmapped reads
      read_counter(1'b1);
      repeat (7) read_counter(1'b0);
      foreach (UNMAPPED[i]) begin
         read_reg(UNMAPPED[i]);
      end
      idle_cycles(2);
      wait_drain();

      // SFP pin changes and sticky bits
      for (int round = 0; round < 2; round++) begin
         @(negedge clk);
         for (int s = 0; s < 2; s++) begin
            r = rand_word();
            new_pins = sfp_pins[s] ^ (r[2:0] | 3'b001);
            m_sticky[s] = m_sticky[s] | (sfp_pins[s] ^ new_pins);
            sfp_pins[s] = new_pins;
            phy_status[s] = r[31:16];
         end
         idle_cycles(6);
         read_reg(`RB_SFPP_STATUS0);
         read_reg(`RB_SFPP_STATUS0);
         read_reg(`RB_SFPP_STATUS1);
         read_reg(`RB_SFPP_STATUS1);
         idle_cycles(2);
         wait_drain();
      end

      // Read burst under random back-pressure
      @(posedge clk);
      bp_en = 1'b1;
      for (int i = 0; i < BURST_LEN; i++) begin
         r = rand_word();
         read_reg(BURST_ADDRS[r[31:16] % 7]);
      end
      idle_cycles(1);
      wait_drain();
      @(posedge clk);
      bp_en = 1'b0;
      idle_cycles(4);

      $display("Errors: %0d, other failures: %0d", err_count, fail_count);
      if (err_count == 0 && fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
bus_host_pkg.sv
bus_board_pkg.sv
bus_cmd_if.sv
bus_cmd_decode.sv
bus_reg_execute.sv
bus_readback_result.sv
bus_ctrl_top.sv
tb_bus_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the board-control testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) bus_ctrl_defs.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
